// File: icache.f
design/cachePkg.sv
design/dataSram.sv
design/tagValidArray.sv
design/refillUnit.sv
design/cacheCtrl.sv
design/cacheTop.sv
sim/cacheTb_assert.sv
sim/cacheTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 --top-module cacheTb -f icache.f -o cacheTbSim \
  && ./obj_dir/cacheTbSim \
  || { echo "cache simulation did not pass"; exit 1; }

// File: sim/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  localparam int ACCEPT_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT  = 300;
  localparam int M_IDLE  = 0;
  localparam int M_WAIT  = 1;
  localparam int M_READY = 2;
  localparam int M_BEATS = 3;

  logic           clk = 1'b0;
  logic           rst_n;
  cachePkg::addrT addr_i;
  logic           valid_i;
  logic           addrOk_o;
  logic           dataOk_o;
  cachePkg::wordT rdData_o;
  logic           memRdValid_o;
  logic           memRdReady_i;
  cachePkg::addrT memAddr_o;
  logic           memDataValid_i;
  logic           memLast_i;
  cachePkg::wordT memData_i;

  // expected responses in order and predicted line requests
  cachePkg::wordT expWordQ [$];
  logic           expHitQ [$];
  int             expCycleQ [$];
  cachePkg::addrT expReqQ [$];
  int             cycles = 0;
  int             reqCount = 0;
  int             missCount = 0;

  // reference cache state for 2 ways by 64 sets
  cachePkg::tagT refTag [2][64];
  logic          refValid [2][64];
  logic          refLru [64];

  int             memMode;
  int             memDelay;
  logic [2:0]     memBeat;
  cachePkg::addrT memLine;
  cachePkg::wordT cmpWord;
  logic           cmpHit;
  int             cmpCycle;

  cacheTop i_cacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (addr_i),
    .valid_i        (valid_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memAddr_o      (memAddr_o),
    .memDataValid_i (memDataValid_i),
    .memLast_i      (memLast_i),
    .memData_i      (memData_i)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
  end

  // memory content as a function of the beat address
  function automatic cachePkg::wordT beatPattern(cachePkg::addrT a);
    return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b1) ^ 32'h0f1e_2d3c};
  endfunction

  function automatic cachePkg::wordT expWord(cachePkg::addrT a);
    return beatPattern({a[31:3], 3'b000});
  endfunction

  function automatic cachePkg::addrT lineWordAddr(int line, int word);
    return 32'h0000_1000 + 32'(line * 32 + word * 8);
  endfunction

  task automatic failWith(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      failWith($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // hit or miss prediction with the invalid way first and then lru
  // lru points away from the used way
  task automatic refAccess(input cachePkg::addrT a, output logic hit);
    cachePkg::tagT   tag;
    cachePkg::indexT idx;
    logic            way;
    tag = a[31:11];
    idx = a[10:5];
    hit = 1'b1;
    if (refValid[0][idx] && refTag[0][idx] == tag) begin
      way = 1'b0;
    end else if (refValid[1][idx] && refTag[1][idx] == tag) begin
      way = 1'b1;
    end else begin
      hit = 1'b0;
      way = !refValid[0][idx] ? 1'b0 : (!refValid[1][idx] ? 1'b1 : refLru[idx]);
      refTag[way][idx]   = tag;
      refValid[way][idx] = 1'b1;
      missCount++;
      expReqQ.push_back({a[31:5], 5'b00000});
    end
    refLru[idx] = ~way;
  endtask

  // hold a request until accepted
  // valid_i stays high on return
  task automatic fetchOne(input cachePkg::addrT a, output int acceptCycle);
    int   waitCnt;
    logic hit;
    addr_i  = a;
    valid_i = 1'b1;
    waitCnt = 0;
    @(negedge clk);
    while (!addrOk_o) begin
      waitCnt++;
      if (waitCnt > ACCEPT_TIMEOUT) begin
        failWith("fetch request was not accepted within the timeout");
      end
      @(negedge clk);
    end
    refAccess(a, hit);
    acceptCycle = cycles + 1;
    expWordQ.push_back(expWord(a));
    expHitQ.push_back(hit);
    expCycleQ.push_back(acceptCycle);
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    int waitCnt;
    waitCnt = 0;
    while (expWordQ.size() != 0) begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > DRAIN_TIMEOUT) begin
        failWith("cache response did not arrive within the timeout");
      end
    end
    @(posedge clk);
    #1;
  endtask

  // response checker
  always @(negedge clk) begin
    if (rst_n && dataOk_o) begin
      if (expWordQ.size() == 0) begin
        failWith("dataOk_o pulsed with no request outstanding");
      end
      cmpWord  = expWordQ.pop_front();
      cmpHit   = expHitQ.pop_front();
      cmpCycle = expCycleQ.pop_front();
      checkVal("rdData_o", rdData_o, cmpWord);
      if (cmpHit) begin
        checkVal("hit response cycle", 64'(cycles), 64'(cmpCycle));
      end
    end
  end

  // memory request monitor
  always @(negedge clk) begin
    if (rst_n && memRdValid_o && memRdReady_i) begin
      reqCount++;
      if (expReqQ.size() == 0) begin
        failWith("memory request that the reference model did not predict");
      end
      checkVal("memAddr_o", 64'(memAddr_o), 64'(expReqQ.pop_front()));
    end
  end

  // memory model with a random accept delay and random gaps between beats
  always @(posedge clk) begin
    #1;
    memDataValid_i = 1'b0;
    memLast_i      = 1'b0;
    if (!rst_n) begin
      memMode      = M_IDLE;
      memRdReady_i = 1'b0;
    end else begin
      case (memMode)
        M_IDLE: begin
          if (memRdValid_o) begin
            memDelay = $urandom_range(0, 3);
            memMode  = M_WAIT;
          end
        end
        M_READY: begin
          // valid drops once the request was taken
          if (!memRdValid_o) begin
            memRdReady_i = 1'b0;
            memLine      = memAddr_o;
            memBeat      = 3'd0;
            memMode      = M_BEATS;
          end
        end
        M_BEATS: begin
          if ($urandom_range(0, 2) != 0) begin
            memDataValid_i = 1'b1;
            memData_i      = beatPattern(memLine | {27'd0, memBeat[1:0], 3'b000});
            memLast_i      = (memBeat == 3'd3);
            if (memBeat == 3'd3) begin
              memMode = M_IDLE;
            end
            memBeat = memBeat + 3'd1;
          end
        end
        default: begin
        end
      endcase
      if (memMode == M_WAIT) begin
        if (memDelay == 0) begin
          memRdReady_i = 1'b1;
          memMode      = M_READY;
        end else begin
          memDelay--;
        end
      end
    end
  end

  initial begin
    int             acc;
    int             prevAcc;
    cachePkg::addrT setLine [3];
    cachePkg::addrT a;
    void'($urandom(32'h35d9));
    rst_n          = 1'b0;
    addr_i         = '0;
    valid_i        = 1'b0;
    memRdReady_i   = 1'b0;
    memDataValid_i = 1'b0;
    memLast_i      = 1'b0;
    memData_i      = '0;
    for (int s = 0; s < 64; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refLru[s]      = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checkVal("addrOk_o after reset", 64'(addrOk_o), 64'd1);
    checkVal("dataOk_o after reset", 64'(dataOk_o), 64'd0);
    checkVal("memRdValid_o after reset", 64'(memRdValid_o), 64'd0);
    @(posedge clk);
    #1;

    // cold misses with one request per line
    for (int i = 0; i < 8; i++) begin
      fetchOne(lineWordAddr(i, i % 4), acc);
      valid_i = 1'b0;
      drain();
    end
    checkVal("cold miss request count", 64'(reqCount), 64'd8);

    // every word of the present lines hits
    for (int i = 0; i < 8; i++) begin
      for (int w = 0; w < 4; w++) begin
        fetchOne(lineWordAddr(i, w), acc);
        valid_i = 1'b0;
        drain();
      end
    end
    checkVal("request count after hits", 64'(reqCount), 64'd8);

    // pipelined hits with one accept per cycle
    for (int k = 0; k < 16; k++) begin
      prevAcc = acc;
      fetchOne(lineWordAddr((k * 3) % 8, k % 4), acc);
      if (k > 0) begin
        checkVal("back-to-back accept cycle", 64'(acc), 64'(prevAcc + 1));
      end
    end
    valid_i = 1'b0;
    drain();
    checkVal("request count after pipelined hits", 64'(reqCount), 64'd8);

    // three lines in set 20 in the order A B A C B A
    setLine[0] = 32'h0004_0280;
    setLine[1] = 32'h0004_0a80;
    setLine[2] = 32'h0004_1280;
    for (int k = 0; k < 6; k++) begin
      a = setLine[(k == 3) ? 2 : ((k == 1 || k == 4) ? 1 : 0)] | 32'(8 * (k % 4));
      fetchOne(a, acc);
      valid_i = 1'b0;
      drain();
    end
    checkVal("request count after set conflicts", 64'(reqCount), 64'(missCount));

    // random fetches over four tags and four sets
    for (int k = 0; k < 200; k++) begin
      a = 32'h0010_0000 | (32'($urandom_range(0, 3)) << 11) |
          (32'($urandom_range(0, 3)) << 5) | (32'($urandom_range(0, 3)) << 3);
      fetchOne(a, acc);
      valid_i = 1'b0;
      drain();
    end
    checkVal("total memory request count", 64'(reqCount), 64'(missCount));
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: sim/cacheTb_assert.sv
`timescale 1ns/1ps

module cacheCtrlAssert (
  input logic                clk,
  input logic                rst_n,
  input cachePkg::ctrlStateT state_i,
  input logic                hitA_i,
  input logic                hitB_i,
  input logic                dataOk_i,
  input cachePkg::addrT      refillAddr_i
);

  // line address must not move while the refill is outstanding
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == cachePkg::MISS || state_i == cachePkg::REFILL) |-> $stable(refillAddr_i))
    else $error("refill address changed before the refill completed");

  // a line lives in at most one way
  assert property (@(posedge clk) disable iff (!rst_n)
    !(hitA_i && hitB_i))
    else $error("tag hit in both ways");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_i && state_i == cachePkg::IDLE))
    else $error("dataOk_o high while the controller is idle");

endmodule

bind cacheCtrl cacheCtrlAssert i_cacheCtrlAssert (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (state),
  .hitA_i       (hitA),
  .hitB_i       (hitB),
  .dataOk_i     (dataOk_o),
  .refillAddr_i (refillAddr_o)
);

// File: design/cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
  input  logic           clk,
  input  logic           rst_n,
  input  cachePkg::addrT addr_i,
  input  logic           valid_i,
  output logic           addrOk_o,
  output logic           dataOk_o,
  output cachePkg::wordT rdData_o,
  output logic           memRdValid_o,
  input  logic           memRdReady_i,
  output cachePkg::addrT memAddr_o,
  input  logic           memDataValid_i,
  input  logic           memLast_i,
  input  cachePkg::wordT memData_i
);

  localparam int NUM_SETS = 1 << cachePkg::INDEX_W;
  localparam int HALF_W   = $bits(cachePkg::halfLineT);

  logic               lookupEn;
  cachePkg::indexT    lookupIndex;
  cachePkg::tagT      tagA;
  cachePkg::tagT      tagB;
  logic               validA;
  logic               validB;
  logic               lruWay;
  logic               fillEn;
  logic               fillWay;
  cachePkg::tagT      fillTag;
  logic               touchEn;
  logic               touchWay;
  logic               ramEn;
  cachePkg::indexT    ramAddr;
  logic [3:0]         ramWen;
  cachePkg::lineT     ramWrData;
  cachePkg::halfLineT ramRdData [4];
  logic               refillStart;
  cachePkg::addrT     refillAddr;
  logic               refillDone;
  cachePkg::lineT     refillLine;

  cacheCtrl i_cacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_i        (addr_i),
    .valid_i       (valid_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .lookupEn_o    (lookupEn),
    .lookupIndex_o (lookupIndex),
    .tagA_i        (tagA),
    .tagB_i        (tagB),
    .validA_i      (validA),
    .validB_i      (validB),
    .lruWay_i      (lruWay),
    .fillEn_o      (fillEn),
    .fillWay_o     (fillWay),
    .fillTag_o     (fillTag),
    .touchEn_o     (touchEn),
    .touchWay_o    (touchWay),
    .ramEn_o       (ramEn),
    .ramAddr_o     (ramAddr),
    .ramWen_o      (ramWen),
    .ramRdDataA_i  ({ramRdData[1], ramRdData[0]}),
    .ramRdDataB_i  ({ramRdData[3], ramRdData[2]}),
    .ramWrData_o   (ramWrData),
    .refillStart_o (refillStart),
    .refillAddr_o  (refillAddr),
    .refillDone_i  (refillDone),
    .refillLine_i  (refillLine)
  );

  tagValidArray #(
    .NUM_SETS (NUM_SETS)
  ) i_tagValidArray (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .tagA_o        (tagA),
    .tagB_o        (tagB),
    .validA_o      (validA),
    .validB_o      (validB),
    .lruWay_o      (lruWay),
    .fillEn_i      (fillEn),
    .fillWay_i     (fillWay),
    .fillTag_i     (fillTag),
    .touchEn_i     (touchEn),
    .touchWay_i    (touchWay)
  );

  // instances 0,1 form way A and 2,3 way B, even instance holds the low half
  for (genvar i = 0; i < 4; i++) begin : g_ram
    dataSram #(
      .NUM_SETS (NUM_SETS)
    ) i_dataSram (
      .clk      (clk),
      .en_i     (ramEn),
      .wen_i    (ramWen[i]),
      .addr_i   (ramAddr),
      .wrData_i (ramWrData[(i % 2) * HALF_W +: HALF_W]),
      .rdData_o (ramRdData[i])
    );
  end

  refillUnit i_refillUnit (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillStart_i  (refillStart),
    .refillAddr_i   (refillAddr),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memAddr_o      (memAddr_o),
    .memDataValid_i (memDataValid_i),
    .memLast_i      (memLast_i),
    .memData_i      (memData_i),
    .refillDone_o   (refillDone),
    .refillLine_o   (refillLine)
  );

endmodule

// File: design/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic            clk,
  input  logic            rst_n,
  input  cachePkg::addrT  addr_i,
  input  logic            valid_i,
  output logic            addrOk_o,
  output logic            dataOk_o,
  output cachePkg::wordT  rdData_o,
  output logic            lookupEn_o,
  output cachePkg::indexT lookupIndex_o,
  input  cachePkg::tagT   tagA_i,
  input  cachePkg::tagT   tagB_i,
  input  logic            validA_i,
  input  logic            validB_i,
  input  logic            lruWay_i,
  output logic            fillEn_o,
  output logic            fillWay_o,
  output cachePkg::tagT   fillTag_o,
  output logic            touchEn_o,
  output logic            touchWay_o,
  output logic            ramEn_o,
  output cachePkg::indexT ramAddr_o,
  output logic [3:0]      ramWen_o,
  input  cachePkg::lineT  ramRdDataA_i,
  input  cachePkg::lineT  ramRdDataB_i,
  output cachePkg::lineT  ramWrData_o,
  output logic            refillStart_o,
  output cachePkg::addrT  refillAddr_o,
  input  logic            refillDone_i,
  input  cachePkg::lineT  refillLine_i
);

  localparam int SEL_W = $clog2(cachePkg::BEATS);

  cachePkg::ctrlStateT state;
  cachePkg::ctrlStateT nextState;
  cachePkg::addrT      reqAddr;
  cachePkg::tagT       reqTag;
  cachePkg::indexT     reqIndex;
  logic [SEL_W-1:0]    wordSel;
  logic                fwdValid;
  logic                victimWay;
  logic                inLookup;
  logic                inRefill;
  logic                hitA;
  logic                hitB;
  logic                lookupHit;
  logic                lookupMiss;
  logic                accept;

  function automatic cachePkg::wordT pickWord(cachePkg::lineT line, logic [SEL_W-1:0] sel);
    return line[sel * cachePkg::WORD_W +: cachePkg::WORD_W];
  endfunction

  assign reqTag   = reqAddr[cachePkg::ADDR_W-1 -: cachePkg::TAG_W];
  assign reqIndex = reqAddr[cachePkg::OFFSET_W +: cachePkg::INDEX_W];
  // word within the line, address bits 4:3
  assign wordSel  = reqAddr[cachePkg::OFFSET_W-1 -: SEL_W];

  assign inLookup = (state == cachePkg::LOOKUP);
  assign inRefill = (state == cachePkg::REFILL);

  // tag compare, skipped in the cycle that returns a forwarded word
  assign hitA       = inLookup && !fwdValid && validA_i && (tagA_i == reqTag);
  assign hitB       = inLookup && !fwdValid && validB_i && (tagB_i == reqTag);
  assign lookupHit  = inLookup && (fwdValid || hitA || hitB);
  assign lookupMiss = inLookup && !lookupHit;

  // fetch side
  assign addrOk_o = (state == cachePkg::IDLE) || lookupHit;
  assign accept   = valid_i && addrOk_o;
  assign dataOk_o = lookupHit;
  assign rdData_o = fwdValid ? pickWord(refillLine_i, wordSel) :
                    hitB     ? pickWord(ramRdDataB_i, wordSel) :
                               pickWord(ramRdDataA_i, wordSel);

  // tag array control
  assign lookupEn_o    = accept;
  assign lookupIndex_o = addr_i[cachePkg::OFFSET_W +: cachePkg::INDEX_W];
  assign fillEn_o      = inRefill;
  assign fillWay_o     = victimWay;
  assign fillTag_o     = reqTag;
  assign touchEn_o     = hitA || hitB;
  assign touchWay_o    = hitB;

  // data RAMs: read on accept, line write in REFILL
  assign ramEn_o     = accept || inRefill;
  assign ramAddr_o   = inRefill ? reqIndex : lookupIndex_o;
  assign ramWen_o    = !inRefill ? 4'b0000 : (victimWay ? 4'b1100 : 4'b0011);
  assign ramWrData_o = refillLine_i;

  // refill request, line aligned
  assign refillStart_o = lookupMiss;
  assign refillAddr_o  = {reqAddr[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                          {cachePkg::OFFSET_W{1'b0}}};

  always_comb begin
    nextState = state;
    unique case (state)
      cachePkg::IDLE: begin
        if (valid_i) begin
          nextState = cachePkg::LOOKUP;
        end
      end
      cachePkg::LOOKUP: begin
        if (lookupMiss) begin
          nextState = cachePkg::MISS;
        end else if (!valid_i) begin
          nextState = cachePkg::IDLE;
        end
      end
      cachePkg::MISS: begin
        if (refillDone_i) begin
          nextState = cachePkg::REFILL;
        end
      end
      // back to LOOKUP to return the forwarded word
      cachePkg::REFILL: begin
        nextState = cachePkg::LOOKUP;
      end
      default: begin
        nextState = cachePkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cachePkg::IDLE;
      fwdValid  <= 1'b0;
      victimWay <= 1'b0;
    end else begin
      state    <= nextState;
      fwdValid <= inRefill;
      // invalid way first, else lru
      if (lookupMiss) begin
        victimWay <= !validA_i ? 1'b0 : (!validB_i ? 1'b1 : lruWay_i);
      end
    end
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

endmodule

// File: design/refillUnit.sv
`timescale 1ns/1ps

module refillUnit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           refillStart_i,
  input  cachePkg::addrT refillAddr_i,
  output logic           memRdValid_o,
  input  logic           memRdReady_i,
  output cachePkg::addrT memAddr_o,
  input  logic           memDataValid_i,
  input  logic           memLast_i,
  input  cachePkg::wordT memData_i,
  output logic           refillDone_o,
  output cachePkg::lineT refillLine_o
);

  localparam int CNT_W = $clog2(cachePkg::BEATS);

  logic             busy;
  logic [CNT_W-1:0] beatCnt;
  logic             beatTake;

  // beats only count while a line is outstanding
  assign beatTake = busy && memDataValid_i;

  // request handshake and beat bookkeeping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdValid_o <= 1'b0;
      busy         <= 1'b0;
      beatCnt      <= '0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= beatTake && memLast_i;
      if (refillStart_i) begin
        memRdValid_o <= 1'b1;
        busy         <= 1'b1;
        beatCnt      <= '0;
      end else begin
        if (memRdValid_o && memRdReady_i) begin
          memRdValid_o <= 1'b0;
        end
        if (beatTake) begin
          beatCnt <= beatCnt + 1'b1;
          if (memLast_i) begin
            busy <= 1'b0;
          end
        end
      end
    end
  end

  // line address held stable until accepted
  always_ff @(posedge clk) begin
    if (refillStart_i) begin
      memAddr_o <= refillAddr_i;
    end
  end

  // beats land by position, word 0 first
  always_ff @(posedge clk) begin
    if (beatTake) begin
      refillLine_o[beatCnt * cachePkg::WORD_W +: cachePkg::WORD_W] <= memData_i;
    end
  end

endmodule

// File: design/tagValidArray.sv
`timescale 1ns/1ps

module tagValidArray #(
  parameter int NUM_SETS = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            lookupEn_i,
  input  cachePkg::indexT lookupIndex_i,
  output cachePkg::tagT   tagA_o,
  output cachePkg::tagT   tagB_o,
  output logic            validA_o,
  output logic            validB_o,
  output logic            lruWay_o,
  input  logic            fillEn_i,
  input  logic            fillWay_i,
  input  cachePkg::tagT   fillTag_i,
  input  logic            touchEn_i,
  input  logic            touchWay_i
);

  localparam int IDX_W = $clog2(NUM_SETS);

  cachePkg::tagT       tagMemA [NUM_SETS];
  cachePkg::tagT       tagMemB [NUM_SETS];
  logic [NUM_SETS-1:0] validA;
  logic [NUM_SETS-1:0] validB;
  // lru bit names the way to replace next
  logic [NUM_SETS-1:0] lru;
  logic [IDX_W-1:0]    lookIdx;
  logic [IDX_W-1:0]    heldIdx;

  assign lookIdx = lookupIndex_i[IDX_W-1:0];

  // tag storage and tag read port
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagA_o <= tagMemA[lookIdx];
      tagB_o <= tagMemB[lookIdx];
    end
    if (fillEn_i && !fillWay_i) begin
      tagMemA[heldIdx] <= fillTag_i;
    end
    if (fillEn_i && fillWay_i) begin
      tagMemB[heldIdx] <= fillTag_i;
    end
  end

  // valid and lru state
  // updates go to the set of the last lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validA   <= '0;
      validB   <= '0;
      lru      <= '0;
      heldIdx  <= '0;
      validA_o <= 1'b0;
      validB_o <= 1'b0;
      lruWay_o <= 1'b0;
    end else begin
      if (lookupEn_i) begin
        heldIdx  <= lookIdx;
        validA_o <= validA[lookIdx];
        validB_o <= validB[lookIdx];
        // a hit in the same set this cycle already moves lru
        if (touchEn_i && heldIdx == lookIdx) begin
          lruWay_o <= ~touchWay_i;
        end else begin
          lruWay_o <= lru[lookIdx];
        end
      end
      if (fillEn_i) begin
        if (fillWay_i) begin
          validB[heldIdx] <= 1'b1;
        end else begin
          validA[heldIdx] <= 1'b1;
        end
        lru[heldIdx] <= ~fillWay_i;
      end else if (touchEn_i) begin
        // other way becomes the replacement candidate
        lru[heldIdx] <= ~touchWay_i;
      end
    end
  end

endmodule

// File: design/dataSram.sv
`timescale 1ns/1ps

module dataSram #(
  parameter int NUM_SETS = 64
) (
  input  logic               clk,
  input  logic               en_i,
  input  logic               wen_i,
  input  cachePkg::indexT    addr_i,
  input  cachePkg::halfLineT wrData_i,
  output cachePkg::halfLineT rdData_o
);

  localparam int IDX_W = $clog2(NUM_SETS);

  cachePkg::halfLineT mem [NUM_SETS];

  // single port, read data registered
  // output holds its last value during a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (wen_i) begin
        mem[addr_i[IDX_W-1:0]] <= wrData_i;
      end else begin
        rdData_o <= mem[addr_i[IDX_W-1:0]];
      end
    end
  end

endmodule

// File: design/cachePkg.sv
package cachePkg;

  // address split: tag | index | offset
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // fetch word and line shape
  localparam int WORD_W = 64;
  localparam int BEATS  = 4;

  typedef logic [ADDR_W-1:0]       addrT;
  typedef logic [TAG_W-1:0]        tagT;
  typedef logic [INDEX_W-1:0]      indexT;
  typedef logic [WORD_W-1:0]       wordT;

  // one data RAM holds half a line
  typedef logic [2*WORD_W-1:0]     halfLineT;
  typedef logic [BEATS*WORD_W-1:0] lineT;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL
  } ctrlStateT;

endpackage
